/* design/miniMemPkg.sv */
package miniMemPkg;

    // ========================================
    // Field widths
    // ========================================
    parameter int ADDR_W      = 32;             // Byte address
    parameter int DATA_W      = 32;             // One word
    parameter int TILE_ID_W   = 8;              // Tile ID in address bits 31:24
    parameter int BYTE_EN_W   = DATA_W / 8;     // One enable per byte
    parameter int FAB_READY_W = 4;              // Fabric ready vector

    typedef logic [TILE_ID_W-1:0] tileIdT;

    // Fabric opcodes
    typedef enum logic [1:0] {
        RD     = 2'b00,     // Read request
        WR     = 2'b01,     // Write request
        RD_RSP = 2'b10      // Read response
    } opcodeT;

    // ========================================
    // Fabric transaction, 74 bits
    // ========================================
    typedef struct packed {
        logic [ADDR_W-1:0] address;     // Target tile ID in top byte
        logic [DATA_W-1:0] data;
        opcodeT            opcode;
        tileIdT            requestorId; // Tile that issued the request
    } tileTrans;

endpackage

/* design/dualPortRam.sv */
`timescale 1ns/100ps

module dualPortRam #(
    parameter int DMEM_ADRS_MSB = 11
) (
    input  logic                             clock,
    // Port A, core side
    input  logic [DMEM_ADRS_MSB-2:0]         addrA,     // Word address
    input  logic [miniMemPkg::DATA_W-1:0]    dataA,
    input  logic                             wrEnA,
    input  logic [miniMemPkg::BYTE_EN_W-1:0] byteEnA,
    output logic [miniMemPkg::DATA_W-1:0]    qA,
    // Port B, fabric side
    input  logic [DMEM_ADRS_MSB-2:0]         addrB,
    input  logic [miniMemPkg::DATA_W-1:0]    dataB,
    input  logic                             wrEnB,     // Full word only
    output logic [miniMemPkg::DATA_W-1:0]    qB
);
    import miniMemPkg::*;

    localparam int WORDS = 2 ** (DMEM_ADRS_MSB - 1);

    logic [DATA_W-1:0] mem [0:WORDS-1];    // No init, contents undefined after reset

    // Both ports read the old word on a write
    always_ff @(posedge clock) begin
        qA <= mem[addrA];
        qB <= mem[addrB];
        if (wrEnA) begin
            for (int b = 0; b < BYTE_EN_W; b++) begin
                if (byteEnA[b]) begin
                    mem[addrA][b*8 +: 8] <= dataA[b*8 +: 8];  // Byte lane b
                end
            end
        end
        if (wrEnB) begin
            mem[addrB] <= dataB;
        end
    end

    // Core and fabric must not collide on one word
    aNoWriteCollision: assert property (@(posedge clock)
        !(wrEnA && wrEnB && (addrA == addrB)))
        else $error("dualPortRam: both ports write word %0h", addrA);

endmodule

/* design/transFifo.sv */
`timescale 1ns/100ps

module transFifo #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic                 clock,
    input  logic                 rstN,
    input  logic                 push,
    input  miniMemPkg::tileTrans pushData,
    input  logic                 pop,
    output miniMemPkg::tileTrans popData,      // Head of queue, valid when not empty
    output logic                 full,
    output logic                 almostFull,   // One entry of margin left
    output logic                 empty
);
    import miniMemPkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    tileTrans           storage [0:FIFO_DEPTH-1];
    logic [PTR_W-1:0]   rdPtr;
    logic [PTR_W-1:0]   wrPtr;
    logic [CNT_W-1:0]   count;

    // Wrap at depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clock) begin
        if (push) storage[wrPtr] <= pushData;
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) wrPtr <= nextPtr(wrPtr);
            if (pop)  rdPtr <= nextPtr(rdPtr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Idle or both
            endcase
        end
    end

    assign popData    = storage[rdPtr];
    assign empty      = (count == '0);
    assign full       = (count == CNT_W'(FIFO_DEPTH));
    assign almostFull = (count >= CNT_W'(FIFO_DEPTH - 1));

    aNoOverflow: assert property (@(posedge clock) disable iff (!rstN) !(push && full))
        else $error("transFifo: push while full");
    aNoUnderflow: assert property (@(posedge clock) disable iff (!rstN) !(pop && empty))
        else $error("transFifo: pop while empty");

endmodule

/* design/roundRobinArbiter.sv */
`timescale 1ns/100ps

module roundRobinArbiter (
    input  logic       clock,
    input  logic       rstN,
    input  logic [1:0] request,     // Bit 0 response FIFO, bit 1 request FIFO
    output logic [1:0] grant        // One-hot, pops winner this cycle
);

    logic lastWinner;               // Index of the client granted last

    // ========================================
    // Grant
    // ========================================
    always_comb begin
        if (request == 2'b11) begin
            grant = lastWinner ? 2'b01 : 2'b10;    // Loser of last round goes first
        end else begin
            grant = request;                        // Lone requester or none
        end
    end

    // Reset as if client 1 just won, so responses go first
    always_ff @(posedge clock) begin
        if (!rstN) begin
            lastWinner <= 1'b1;
        end else if (|grant) begin
            lastWinner <= grant[1];
        end
    end

    // Under contention the grant moves to the other client
    aGrantRotates: assert property (@(posedge clock) disable iff (!rstN)
        (|grant) |=> (request != 2'b11) || (grant != $past(grant)))
        else $error("roundRobinArbiter: client %0d won twice under contention", grant[1]);

endmodule

/* design/coreDataPort.sv */
`timescale 1ns/100ps

module coreDataPort #(
    parameter int DMEM_ADRS_MSB = 11
) (
    input  logic                             clock,
    input  logic                             rstN,
    input  miniMemPkg::tileIdT               localTileId,
    // Core data port
    input  logic [miniMemPkg::ADDR_W-1:0]    dMemAddress,
    input  logic [miniMemPkg::DATA_W-1:0]    dMemWrData,
    input  logic [miniMemPkg::BYTE_EN_W-1:0] dMemByteEn,
    input  logic                             dMemWrEn,
    input  logic                             dMemRdEn,
    output logic [miniMemPkg::DATA_W-1:0]    dMemRdRsp,
    output logic                             dMemReady,
    // Inbound fabric, watched for the read response
    input  logic                             inFabricValid,
    input  miniMemPkg::opcodeT               inFabricOpcode,
    input  logic [miniMemPkg::DATA_W-1:0]    inFabricData,
    // Request FIFO
    input  logic                             reqFull,
    output logic                             reqPush,
    output miniMemPkg::tileTrans             reqData,
    // Memory port A
    output logic [DMEM_ADRS_MSB-2:0]         ramAddr,
    output logic [miniMemPkg::DATA_W-1:0]    ramWrData,
    output logic [miniMemPkg::BYTE_EN_W-1:0] ramByteEn,
    output logic                             ramWrEn,
    input  logic [miniMemPkg::DATA_W-1:0]    ramRdData
);
    import miniMemPkg::*;

    tileIdT            tileId;
    logic              isLocal;
    logic [1:0]        byteOff;
    logic [1:0]        byteOffQ;        // Offset of the read in flight
    logic              outstanding;     // Remote read waiting for RD_RSP
    logic              rspAccept;
    logic              rspValidQ;
    logic [DATA_W-1:0] rspDataQ;

    // ========================================
    // Decode and local access
    // ========================================
    assign tileId  = dMemAddress[ADDR_W-1 -: TILE_ID_W];
    assign isLocal = (tileId == localTileId) || (tileId == '0);   // Zero aliases to local
    assign byteOff = dMemAddress[1:0];

    assign ramAddr   = dMemAddress[DMEM_ADRS_MSB:2];
    assign ramWrData = dMemWrData << {byteOff, 3'b000};    // Align to byte lane
    assign ramByteEn = dMemByteEn << byteOff;
    assign ramWrEn   = dMemWrEn && isLocal;

    // ========================================
    // Remote requests
    // ========================================
    assign dMemReady = !outstanding && !reqFull;
    assign reqPush   = (dMemWrEn || dMemRdEn) && !isLocal && dMemReady;

    always_comb begin
        reqData.address     = dMemAddress;
        reqData.data        = dMemWrData;              // Unshifted, remote tile aligns
        reqData.opcode      = dMemWrEn ? WR : RD;
        reqData.requestorId = localTileId;
    end

    assign rspAccept = outstanding && inFabricValid && (inFabricOpcode == RD_RSP);

    always_ff @(posedge clock) begin
        if (!rstN) begin
            outstanding <= 1'b0;
            rspValidQ   <= 1'b0;
        end else begin
            if (reqPush && dMemRdEn) outstanding <= 1'b1;
            else if (rspAccept)      outstanding <= 1'b0;
            rspValidQ <= rspAccept;
        end
    end

    always_ff @(posedge clock) begin
        byteOffQ <= byteOff;
        if (rspAccept) rspDataQ <= inFabricData;
    end

    // Response data first, else local word shifted down and zero filled
    assign dMemRdRsp = rspValidQ ? rspDataQ : (ramRdData >> {byteOffQ, 3'b000});

    // A remote access while a read is outstanding would be dropped
    aNoPushWhileOutstanding: assert property (@(posedge clock) disable iff (!rstN)
        outstanding |-> !((dMemWrEn || dMemRdEn) && !isLocal))
        else $error("coreDataPort: remote access while read outstanding");

endmodule

/* design/fabricSlavePort.sv */
`timescale 1ns/100ps

module fabricSlavePort #(
    parameter int DMEM_ADRS_MSB = 11
) (
    input  logic                          clock,
    input  logic                          rstN,
    input  miniMemPkg::tileIdT            localTileId,
    // Inbound fabric
    input  logic                          inFabricValid,
    input  logic [miniMemPkg::ADDR_W-1:0] inFabricAddress,
    input  logic [miniMemPkg::DATA_W-1:0] inFabricData,
    input  miniMemPkg::opcodeT            inFabricOpcode,
    input  miniMemPkg::tileIdT            inFabricRequestorId,
    // Memory port B
    output logic [DMEM_ADRS_MSB-2:0]      ramAddr,
    output logic [miniMemPkg::DATA_W-1:0] ramWrData,
    output logic                          ramWrEn,
    input  logic [miniMemPkg::DATA_W-1:0] ramRdData,
    // Response FIFO
    output logic                          rspPush,
    output miniMemPkg::tileTrans          rspData
);
    import miniMemPkg::*;

    logic              rdHit;
    logic              rdHitQ;          // Memory word valid this cycle
    logic [ADDR_W-1:0] rspAddrQ;

    // ========================================
    // Memory access
    // ========================================
    assign ramAddr   = inFabricAddress[DMEM_ADRS_MSB:2];
    assign ramWrData = inFabricData;
    assign ramWrEn   = inFabricValid && (inFabricOpcode == WR);
    assign rdHit     = inFabricValid && (inFabricOpcode == RD);

    // ========================================
    // Read response header
    // ========================================
    always_ff @(posedge clock) begin
        if (!rstN) begin
            rdHitQ <= 1'b0;
        end else begin
            rdHitQ <= rdHit;
        end
    end

    // Response goes back to the requestor's tile
    always_ff @(posedge clock) begin
        if (rdHit) begin
            rspAddrQ <= {inFabricRequestorId, inFabricAddress[ADDR_W-TILE_ID_W-1:0]};
        end
    end

    assign rspPush = rdHitQ;            // Pushed with the read word

    always_comb begin
        rspData.address     = rspAddrQ;
        rspData.data        = ramRdData;
        rspData.opcode      = RD_RSP;
        rspData.requestorId = localTileId;  // Responder is this tile
    end

endmodule

/* design/miniMemWrap.sv */
`timescale 1ns/100ps

module miniMemWrap #(
    parameter int DMEM_ADRS_MSB = 11,   // 1024 words
    parameter int FIFO_DEPTH    = 2
) (
    input  logic                               clock,
    input  logic                               rstN,
    input  miniMemPkg::tileIdT                 localTileId,
    // Core data port
    input  logic [miniMemPkg::ADDR_W-1:0]      dMemAddress,
    input  logic [miniMemPkg::DATA_W-1:0]      dMemWrData,
    input  logic [miniMemPkg::BYTE_EN_W-1:0]   dMemByteEn,
    input  logic                               dMemWrEn,
    input  logic                               dMemRdEn,
    output logic [miniMemPkg::DATA_W-1:0]      dMemRdRsp,
    output logic                               dMemReady,
    // Fabric in
    input  logic                               inFabricValid,
    input  logic [miniMemPkg::ADDR_W-1:0]      inFabricAddress,
    input  logic [miniMemPkg::DATA_W-1:0]      inFabricData,
    input  miniMemPkg::opcodeT                 inFabricOpcode,
    input  miniMemPkg::tileIdT                 inFabricRequestorId,
    output logic                               miniCoreReady,
    // Fabric out
    output logic                               outFabricValid,
    output logic [miniMemPkg::ADDR_W-1:0]      outFabricAddress,
    output logic [miniMemPkg::DATA_W-1:0]      outFabricData,
    output miniMemPkg::opcodeT                 outFabricOpcode,
    output miniMemPkg::tileIdT                 outFabricRequestorId,
    input  logic [miniMemPkg::FAB_READY_W-1:0] fabReady
);
    import miniMemPkg::*;

    logic [DMEM_ADRS_MSB-2:0] ramAddrA, ramAddrB;
    logic [DATA_W-1:0]        ramWrDataA, ramWrDataB, ramQA, ramQB;
    logic [BYTE_EN_W-1:0]     ramByteEnA;
    logic                     ramWrEnA, ramWrEnB;
    logic                     rspPush, rspAlmostFull, rspEmpty;
    logic                     reqPush, reqFull, reqEmpty;
    tileTrans                 rspIn, rspHead, reqIn, reqHead, outTrans;
    logic [1:0]               request, grant;

    coreDataPort #(.DMEM_ADRS_MSB(DMEM_ADRS_MSB)) uCoreDataPort (
        .clock, .rstN, .localTileId,
        .dMemAddress, .dMemWrData, .dMemByteEn, .dMemWrEn, .dMemRdEn, .dMemRdRsp, .dMemReady,
        .inFabricValid, .inFabricOpcode, .inFabricData,
        .reqFull, .reqPush, .reqData(reqIn),
        .ramAddr(ramAddrA), .ramWrData(ramWrDataA), .ramByteEn(ramByteEnA),
        .ramWrEn(ramWrEnA), .ramRdData(ramQA));

    fabricSlavePort #(.DMEM_ADRS_MSB(DMEM_ADRS_MSB)) uFabricSlavePort (
        .clock, .rstN, .localTileId,
        .inFabricValid, .inFabricAddress, .inFabricData, .inFabricOpcode, .inFabricRequestorId,
        .ramAddr(ramAddrB), .ramWrData(ramWrDataB), .ramWrEn(ramWrEnB), .ramRdData(ramQB),
        .rspPush, .rspData(rspIn));

    dualPortRam #(.DMEM_ADRS_MSB(DMEM_ADRS_MSB)) uDataMem (
        .clock,
        .addrA(ramAddrA), .dataA(ramWrDataA), .wrEnA(ramWrEnA), .byteEnA(ramByteEnA), .qA(ramQA),
        .addrB(ramAddrB), .dataB(ramWrDataB), .wrEnB(ramWrEnB), .qB(ramQB));

    // ========================================
    // Outbound queues and arbitration
    // ========================================
    transFifo #(.FIFO_DEPTH(FIFO_DEPTH)) rspFifo (
        .clock, .rstN, .push(rspPush), .pushData(rspIn), .pop(grant[0]), .popData(rspHead),
        .full(), .almostFull(rspAlmostFull), .empty(rspEmpty));

    transFifo #(.FIFO_DEPTH(FIFO_DEPTH)) reqFifo (
        .clock, .rstN, .push(reqPush), .pushData(reqIn), .pop(grant[1]), .popData(reqHead),
        .full(reqFull), .almostFull(), .empty(reqEmpty));

    assign request = {!reqEmpty, !rspEmpty} & {2{&fabReady}};   // Whole fabric must be ready

    roundRobinArbiter uArbiter (.clock, .rstN, .request, .grant);

    assign outTrans = grant[0] ? rspHead :
                      grant[1] ? reqHead : '0;

    assign outFabricValid       = |grant;
    assign outFabricAddress     = outTrans.address;
    assign outFabricData        = outTrans.data;
    assign outFabricOpcode      = outTrans.opcode;
    assign outFabricRequestorId = outTrans.requestorId;
    assign miniCoreReady        = !rspAlmostFull;   // Margin for the RD in flight

endmodule

/* dv/clockGen.sv */
`timescale 1ns/100ps

module clockGen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clock,
    output logic rstN
);

    // Free-running clock, starts low
    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);       // Release away from the sampling edge
        rstN = 1'b1;
    end

endmodule

/* dv/miniMemWrapTb.sv */
`timescale 1ns/100ps

module miniMemWrapTb;
    import miniMemPkg::*;

    localparam int     RESET_CYCLES = 16;
    localparam tileIdT LOCAL_ID     = 8'h05;

    logic                   clock;
    logic                   rstN;
    // DUT inputs
    logic [ADDR_W-1:0]      dMemAddress;
    logic [DATA_W-1:0]      dMemWrData;
    logic [BYTE_EN_W-1:0]   dMemByteEn;
    logic                   dMemWrEn, dMemRdEn;
    logic                   inFabricValid;
    logic [ADDR_W-1:0]      inFabricAddress;
    logic [DATA_W-1:0]      inFabricData;
    opcodeT                 inFabricOpcode;
    tileIdT                 inFabricRequestorId;
    logic [FAB_READY_W-1:0] fabReady;
    // DUT outputs
    logic [DATA_W-1:0]      dMemRdRsp;
    logic                   dMemReady, miniCoreReady, outFabricValid;
    logic [ADDR_W-1:0]      outFabricAddress;
    logic [DATA_W-1:0]      outFabricData;
    opcodeT                 outFabricOpcode;
    tileIdT                 outFabricRequestorId;

    // ========================================
    // Vectors and bookkeeping
    // ========================================
    string       opQ[$];
    logic [31:0] aQ[$], bQ[$], cQ[$], dQ[$];
    logic [73:0] outQ[$];                // Outbound transfers seen on the bus
    int          errorCount = 0;
    int          passCount  = 0;
    int          failCount  = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;         // Zero until vectors are loaded
    integer      seed       = 32'h51622572;

    clockGen #(.PERIOD_NS(40), .RESET_CYCLES(RESET_CYCLES)) uClockGen (.clock, .rstN);

    miniMemWrap dut (
        .clock, .rstN, .localTileId(LOCAL_ID),
        .dMemAddress, .dMemWrData, .dMemByteEn, .dMemWrEn, .dMemRdEn, .dMemRdRsp, .dMemReady,
        .inFabricValid, .inFabricAddress, .inFabricData, .inFabricOpcode, .inFabricRequestorId,
        .miniCoreReady,
        .outFabricValid, .outFabricAddress, .outFabricData, .outFabricOpcode,
        .outFabricRequestorId, .fabReady);

    // A transfer completes at the rising edge while outFabricValid is high
    always @(posedge clock) begin
        if (rstN && outFabricValid) begin
            outQ.push_back({outFabricAddress, outFabricData, outFabricOpcode,
                            outFabricRequestorId});
        end
    end

    always @(posedge clock) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout: run did not finish within %0d clock cycles", cycleLimit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    // Enables off, data buses carry junk
    task automatic idleInputs();
        dMemWrEn            = 1'b0;
        dMemRdEn            = 1'b0;
        dMemByteEn          = '0;
        dMemAddress         = $random(seed);
        dMemWrData          = $random(seed);
        inFabricValid       = 1'b0;
        inFabricAddress     = $random(seed);
        inFabricData        = $random(seed);
        inFabricOpcode      = RD;
        inFabricRequestorId = '0;
    endtask

    // One core access, held for one cycle once dMemReady is high
    task automatic coreDrive(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] be, input logic wr, input logic rd);
        while (!dMemReady) @(negedge clock);
        dMemAddress = addr;
        dMemWrData  = data;
        dMemByteEn  = be;
        dMemWrEn    = wr;
        dMemRdEn    = rd;
        @(negedge clock);
    endtask

    // One inbound fabric beat, sent only while miniCoreReady is high
    task automatic fabricDrive(input logic [31:0] addr, input logic [31:0] data,
                               input opcodeT op, input tileIdT rid);
        while (!miniCoreReady) @(negedge clock);
        inFabricValid       = 1'b1;
        inFabricAddress     = addr;
        inFabricData        = data;
        inFabricOpcode      = op;
        inFabricRequestorId = rid;
        @(negedge clock);
    endtask

    // ========================================
    // One vector, entered and left on a falling edge
    // ========================================
    task automatic runVector(input int i);
        string       name;
        int          errBefore;
        logic [73:0] got;
        name      = $sformatf("%s#%0d", opQ[i], i + 1);
        errBefore = errorCount;
        case (opQ[i])
            "CWR": coreDrive(aQ[i], bQ[i], cQ[i][3:0], 1'b1, 1'b0);
            "CRD": begin
                coreDrive(aQ[i], bQ[i], 4'hf, 1'b0, 1'b1);
                checkValue(name, dQ[i], dMemRdRsp);         // Word one cycle later
            end
            "CRR": begin
                coreDrive(aQ[i], bQ[i], 4'hf, 1'b0, 1'b1);
                checkValue(name, 32'd0, {31'd0, dMemReady});   // Remote read stalls core
            end
            "FWR": fabricDrive(aQ[i], bQ[i], WR, cQ[i][7:0]);
            "FRD": fabricDrive(aQ[i], bQ[i], RD, cQ[i][7:0]);
            "RSP": begin
                checkValue(name, 32'd0, {31'd0, dMemReady});
                fabricDrive(aQ[i], bQ[i], RD_RSP, cQ[i][7:0]);
                checkValue(name, dQ[i], dMemRdRsp);
                checkValue(name, 32'd1, {31'd0, dMemReady});
            end
            "OUT": begin
                while (outQ.size() == 0) @(negedge clock);
                got = outQ.pop_front();
                checkValue(name, aQ[i], got[73:42]);        // Address
                checkValue(name, bQ[i], got[41:10]);        // Data
                checkValue(name, cQ[i], {30'd0, got[9:8]});
                checkValue(name, dQ[i], {24'd0, got[7:0]});
            end
            "READY": fabReady = dQ[i][FAB_READY_W-1:0];
            "QUIET": begin
                checkValue(name, 32'd0, {31'd0, outFabricValid});
                checkValue(name, 32'd0, outQ.size());
                checkValue(name, dQ[i], {30'd0, miniCoreReady, dMemReady});
            end
            "IDLE": repeat (dQ[i]) @(negedge clock);
            default: begin
                $display("Unknown operation %s in vector %0d", opQ[i], i + 1);
                errorCount++;
            end
        endcase
        idleInputs();
        if (errorCount == errBefore) begin
            passCount++;
            $display("%-9s done", name);
        end else begin
            failCount++;
            $display("%-9s failed", name);
        end
    endtask

    // Lines starting with # are comments
    task automatic loadVectors(input int fd);
        string       line;
        string       opName;
        logic [31:0] a, b, c, d;
        int          n;
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                n = $sscanf(line, "%s %h %h %h %h", opName, a, b, c, d);
                if (n == 5) begin
                    opQ.push_back(opName);
                    aQ.push_back(a);
                    bQ.push_back(b);
                    cQ.push_back(c);
                    dQ.push_back(d);
                end else begin
                    $display("Vector line could not be read: %s", line);
                    errorCount++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic runTests();
        cycleLimit = opQ.size() * 20 + RESET_CYCLES;
        wait (rstN === 1'b1);
        @(negedge clock);
        for (int i = 0; i < opQ.size(); i++) begin
            runVector(i);
        end
        repeat (4) @(negedge clock);
        if (outQ.size() != 0) begin
            $display("Outbound bus carried %0d transactions that no test expected", outQ.size());
            errorCount++;
        end
        $display("Tests passed %0d, failed %0d, errors %0d", passCount, failCount, errorCount);
    endtask

    initial begin
        int fd;
        fabReady = '1;
        idleInputs();
        fd = $fopen("dv/miniMemVectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open vector file dv/miniMemVectors.txt");
            $display("FAIL: see errors above");
            $finish;
        end else begin
            loadVectors(fd);
            runTests();
            if (errorCount == 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
            $finish;
        end
    end

endmodule

/* miniMemWrap.f */
design/miniMemPkg.sv
design/dualPortRam.sv
design/transFifo.sv
design/roundRobinArbiter.sv
design/coreDataPort.sv
design/fabricSlavePort.sv
design/miniMemWrap.sv
dv/clockGen.sv
dv/miniMemWrapTb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the miniMemWrap testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
SIM=miniMemWrapSim

# Package carries no timescale, so give files without one the project default
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f miniMemWrap.f --top-module miniMemWrapTb -Mdir "$OBJ" -o "$SIM"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/$SIM" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi
echo "Simulation finished without failure"
exit 0

/* dv/miniMemVectors.txt */
# op addr data c d  (all hex)
# c: byte enables, requestor ID or expected opcode; d: expected value, cycles or fabReady
CWR 05000010 A1B2C3D4 f 0
CRD 05000010 0 0 A1B2C3D4
CWR 05000020 0 f 0
CWR 05000021 5A 1 0
CRD 05000021 0 0 5A
CWR 00000030 0 f 0
CWR 00000032 6B 1 0
CRD 05000032 0 0 6B
CWR 05000040 0 f 0
CWR 05000043 7C 1 0
CRD 00000043 0 0 7C
CRD 05000040 0 0 7C000000
FWR 05000100 CAFEF00D 9 0
CRD 05000100 0 0 CAFEF00D
FRD 05000010 0 9 0
OUT 09000010 A1B2C3D4 2 5
CWR 07000200 DEADBEEF f 0
OUT 07000200 DEADBEEF 1 5
CRR 07000204 13572468 0 0
OUT 07000204 13572468 0 5
IDLE 0 0 0 3
RSP 05000204 2468ACE0 7 2468ACE0
READY 0 0 0 b
FRD 05000100 0 a 0
FRD 05000020 0 b 0
CWR 06000300 11112222 f 0
CWR 06000304 33334444 f 0
QUIET 0 0 0 0
READY 0 0 0 f
OUT 0A000100 CAFEF00D 2 5
OUT 06000300 11112222 1 5
OUT 0B000020 00005A00 2 5
OUT 06000304 33334444 1 5
